// File: src/rv_pkg.sv
`default_nettype none
// ---------------------------------------------------------------------
// shared widths, word types and encodings of the RV32I core
// opcode and branch values follow the ISA; alu ops are {instr[30], funct3}
// ---------------------------------------------------------------------

package rv_pkg;

  localparam int XLEN         = 32;
  localparam int DRAIN_CYCLES = 4;   // cycles to empty the pipe after fetch stops

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // encoded so that decode can build the op straight from the instruction
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_cond_e;

endpackage

`default_nettype wire

// File: src/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none
// ---------------------------------------------------------------------
// combinational integer ALU, shifts use b[4:0] only
// ---------------------------------------------------------------------

module rv_alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_e op,
  output rv_pkg::word_t   y
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb
  begin
    case (op)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_SLL:  y = a << shamt;
      ALU_SLT:  y = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: y = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  y = a ^ b;
      ALU_SRL:  y = a >> shamt;
      ALU_SRA:  y = word_t'($signed(a) >>> shamt);   // sign fill
      ALU_OR:   y = a | b;
      ALU_AND:  y = a & b;
      default:  y = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none
// ---------------------------------------------------------------------
// 31 writable registers, x0 always reads zero
// a write is visible on the read ports in the same cycle
// ---------------------------------------------------------------------

module rv_regfile (
  input  logic              clk,
  input  logic              arst_n,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              wr_en,
  input  rv_pkg::reg_addr_t wr_addr,
  input  rv_pkg::word_t     wr_data
);
  import rv_pkg::*;

  word_t regs [1:31];

  function automatic word_t rd_port(input reg_addr_t addr);
    word_t val;
    if (addr == '0)
      val = '0;
    else if (wr_en && (wr_addr == addr))
      val = wr_data;   // write-through
    else
      val = regs[addr];
    return val;
  endfunction

  always_ff @(posedge clk)
  begin
    if (wr_en && (wr_addr != '0))
      regs[wr_addr] <= wr_data;
  end

  always_comb
  begin
    rs1_data = rd_port(rs1);
    rs2_data = rd_port(rs2);
  end

  // writing x0 leaves it reading zero afterwards
  a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
    (wr_en && (wr_addr == '0)) |=> ((rs1 != '0) || (rs1_data == '0)) &&
                                   ((rs2 != '0) || (rs2_data == '0)));

endmodule

`default_nettype wire

// File: src/rv_fetch.sv
`timescale 1ns/10ps
`default_nettype none
// ---------------------------------------------------------------------
// PC and fetch/decode register; redirect has priority over stall
// an all-zero word stops fetch, halt follows after DRAIN_CYCLES
// a redirect while draining restarts fetch at the target
// ---------------------------------------------------------------------

module rv_fetch #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          stall,
  input  logic          redirect,
  input  rv_pkg::word_t redirect_pc,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_data,
  output logic          if_valid,
  output rv_pkg::word_t if_pc,
  output rv_pkg::word_t if_instr,
  output logic          halt
);
  import rv_pkg::*;

  localparam int CNT_W = $clog2(DRAIN_CYCLES + 1);

  word_t            pc;
  logic             stopped;     // zero word seen, fetch parked
  logic [CNT_W-1:0] drain_cnt;
  logic             zero_word;

  assign imem_addr = pc;
  assign zero_word = (imem_data == '0);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pc        <= RESET_PC;
      if_valid  <= 1'b0;
      stopped   <= 1'b0;
      drain_cnt <= '0;
      halt      <= 1'b0;
    end
    else if (redirect)
    begin
      pc       <= redirect_pc;
      if_valid <= 1'b0;        // squash the wrong-path fetch
      stopped  <= 1'b0;
    end
    else if (stopped)
    begin
      if_valid <= 1'b0;
      if (drain_cnt != '0)
        drain_cnt <= drain_cnt - 1'b1;
      if (drain_cnt == CNT_W'(1))
        halt <= 1'b1;
    end
    else if (!stall)
    begin
      if (zero_word)
      begin
        stopped   <= 1'b1;     // pc stays on the zero word
        drain_cnt <= CNT_W'(DRAIN_CYCLES);
        if_valid  <= 1'b0;
      end
      else
      begin
        pc       <= pc + 32'd4;
        if_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
    begin
      if_pc    <= pc;
      if_instr <= imem_data;
    end
  end

  // branch targets from execute keep the fetch address aligned
  a_pc_align: assert property (@(posedge clk) disable iff (!arst_n)
    imem_addr[1:0] == 2'b00);

  a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    halt |=> halt);

endmodule

`default_nettype wire

// File: src/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none
// ---------------------------------------------------------------------
// field and immediate decode, load-use stall, decode/execute register
// id_rd is zero for instructions without a result, unknown opcodes are nops
// ---------------------------------------------------------------------

module rv_decode (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 if_valid,
  input  rv_pkg::word_t        if_pc,
  input  rv_pkg::word_t        if_instr,
  input  logic                 redirect,
  input  logic                 ex_valid,
  input  rv_pkg::reg_addr_t    ex_rd,
  input  logic                 ex_is_load,
  output rv_pkg::reg_addr_t    rs1,
  output rv_pkg::reg_addr_t    rs2,
  input  rv_pkg::word_t        rs1_data,
  input  rv_pkg::word_t        rs2_data,
  output logic                 stall,
  output logic                 id_valid,
  output rv_pkg::word_t        id_pc,
  output rv_pkg::opcode_e      id_opcode,
  output rv_pkg::alu_op_e      id_alu_op,
  output rv_pkg::branch_cond_e id_br_cond,
  output rv_pkg::reg_addr_t    id_rs1,
  output rv_pkg::reg_addr_t    id_rs2,
  output rv_pkg::reg_addr_t    id_rd,
  output rv_pkg::word_t        id_imm,
  output rv_pkg::word_t        id_rs1_data,
  output rv_pkg::word_t        id_rs2_data
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       alt;       // instr[30], picks sub and sra
  reg_addr_t  rd;
  word_t      imm;
  alu_op_e    alu_op;
  logic       use_rs1;
  logic       use_rs2;

  assign opcode = opcode_e'(if_instr[6:0]);
  assign funct3 = if_instr[14:12];
  assign alt    = if_instr[30];
  assign rs1    = if_instr[19:15];
  assign rs2    = if_instr[24:20];

  always_comb
  begin
    imm     = '0;
    alu_op  = ALU_ADD;   // address add for loads and stores
    rd      = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      OPC_OP:
      begin
        alu_op  = alu_op_e'({alt, funct3});
        rd      = if_instr[11:7];
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OPC_OP_IMM:
      begin
        // only srai reads instr[30], addi has no subtract form
        alu_op  = alu_op_e'({alt && (funct3 == 3'b101), funct3});
        imm     = {{20{if_instr[31]}}, if_instr[31:20]};
        rd      = if_instr[11:7];
        use_rs1 = 1'b1;
      end
      OPC_LOAD:
      begin
        imm     = {{20{if_instr[31]}}, if_instr[31:20]};
        rd      = if_instr[11:7];
        use_rs1 = 1'b1;
      end
      OPC_STORE:
      begin
        imm     = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OPC_BRANCH:
      begin
        imm = {{20{if_instr[31]}}, if_instr[7], if_instr[30:25], if_instr[11:8], 1'b0};
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OPC_LUI:
      begin
        imm = {if_instr[31:12], 12'b0};
        rd  = if_instr[11:7];
      end
      default: ;
    endcase
  end

  // load now in execute feeds this instruction, hold it one cycle
  assign stall = if_valid && id_valid && (id_opcode == OPC_LOAD) && (id_rd != '0) &&
                 ((use_rs1 && (rs1 == id_rd)) || (use_rs2 && (rs2 == id_rd)));

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      id_valid <= 1'b0;
    else if (redirect || stall)
      id_valid <= 1'b0;    // flush or bubble
    else
      id_valid <= if_valid;
  end

  always_ff @(posedge clk)
  begin
    id_pc       <= if_pc;
    id_opcode   <= opcode;
    id_alu_op   <= alu_op;
    id_br_cond  <= branch_cond_e'(funct3);
    id_rs1      <= rs1;
    id_rs2      <= rs2;
    id_rd       <= rd;
    id_imm      <= imm;
    id_rs1_data <= rs1_data;
    id_rs2_data <= rs2_data;
  end

  // the load that caused a stall sits in the memory stage next cycle
  a_stall_load: assert property (@(posedge clk) disable iff (!arst_n)
    (stall && !redirect) |=> ex_valid && ex_is_load && (ex_rd != '0));

endmodule

`default_nettype wire

// File: src/rv_execute.sv
`timescale 1ns/10ps
`default_nettype none
// ---------------------------------------------------------------------
// operand forwarding, ALU, branch resolution and execute/memory register
// redirect is combinational while the taken branch is in this stage
// ---------------------------------------------------------------------

module rv_execute (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 id_valid,
  input  rv_pkg::word_t        id_pc,
  input  rv_pkg::opcode_e      id_opcode,
  input  rv_pkg::alu_op_e      id_alu_op,
  input  rv_pkg::branch_cond_e id_br_cond,
  input  rv_pkg::reg_addr_t    id_rs1,
  input  rv_pkg::reg_addr_t    id_rs2,
  input  rv_pkg::reg_addr_t    id_rd,
  input  rv_pkg::word_t        id_imm,
  input  rv_pkg::word_t        id_rs1_data,
  input  rv_pkg::word_t        id_rs2_data,
  input  logic                 wb_en,
  input  rv_pkg::reg_addr_t    wb_rd,
  input  rv_pkg::word_t        wb_data,
  output logic                 redirect,
  output rv_pkg::word_t        redirect_pc,
  output logic                 ex_valid,
  output rv_pkg::reg_addr_t    ex_rd,
  output rv_pkg::word_t        ex_result,
  output rv_pkg::word_t        ex_store_data,
  output logic                 ex_is_load,
  output logic                 ex_is_store
);
  import rv_pkg::*;

  word_t op_a;
  word_t op_b;     // forwarded rs2, also the store data
  word_t alu_b;
  word_t alu_y;
  logic  taken;

  // newest producer wins, a load in the memory stage has no data yet
  function automatic word_t fwd(input reg_addr_t rs, input word_t rf_data);
    word_t val;
    if (ex_valid && !ex_is_load && (ex_rd != '0) && (ex_rd == rs))
      val = ex_result;
    else if (wb_en && (wb_rd == rs))
      val = wb_data;
    else
      val = rf_data;
    return val;
  endfunction

  always_comb
  begin
    op_a = fwd(id_rs1, id_rs1_data);
    op_b = fwd(id_rs2, id_rs2_data);
  end

  assign alu_b = (id_opcode == OPC_OP) ? op_b : id_imm;

  rv_alu i_alu (
    .a  (op_a),
    .b  (alu_b),
    .op (id_alu_op),
    .y  (alu_y)
  );

  always_comb
  begin
    case (id_br_cond)
      BR_EQ:   taken = (op_a == op_b);
      BR_NE:   taken = (op_a != op_b);
      BR_LT:   taken = $signed(op_a) < $signed(op_b);
      BR_GE:   taken = $signed(op_a) >= $signed(op_b);
      BR_LTU:  taken = op_a < op_b;
      BR_GEU:  taken = op_a >= op_b;
      default: taken = 1'b0;   // reserved funct3 falls through
    endcase
  end

  assign redirect    = id_valid && (id_opcode == OPC_BRANCH) && taken;
  assign redirect_pc = id_pc + id_imm;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ex_valid    <= 1'b0;
      ex_is_load  <= 1'b0;
      ex_is_store <= 1'b0;
    end
    else
    begin
      ex_valid    <= id_valid;
      ex_is_load  <= id_valid && (id_opcode == OPC_LOAD);
      ex_is_store <= id_valid && (id_opcode == OPC_STORE);
    end
  end

  always_ff @(posedge clk)
  begin
    ex_rd         <= id_rd;
    ex_result     <= (id_opcode == OPC_LUI) ? id_imm : alu_y;  // lui skips the ALU
    ex_store_data <= op_b;
  end

endmodule

`default_nettype wire

// File: src/rv_memwb.sv
`timescale 1ns/10ps
`default_nettype none
// ---------------------------------------------------------------------
// word-only data memory access and the writeback register
// dmem_rdata is expected in the same cycle as dmem_rd_en
// ---------------------------------------------------------------------

module rv_memwb (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              ex_valid,
  input  rv_pkg::reg_addr_t ex_rd,
  input  rv_pkg::word_t     ex_result,
  input  rv_pkg::word_t     ex_store_data,
  input  logic              ex_is_load,
  input  logic              ex_is_store,
  output rv_pkg::word_t     dmem_addr,
  output rv_pkg::word_t     dmem_wdata,
  output logic              dmem_wr_en,
  output logic              dmem_rd_en,
  input  rv_pkg::word_t     dmem_rdata,
  output logic              wb_en,
  output rv_pkg::reg_addr_t wb_rd,
  output rv_pkg::word_t     wb_data
);
  import rv_pkg::*;

  assign dmem_addr  = ex_result;       // address computed in execute
  assign dmem_wdata = ex_store_data;
  assign dmem_wr_en = ex_valid && ex_is_store;
  assign dmem_rd_en = ex_valid && ex_is_load;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      wb_en <= 1'b0;
    else
      wb_en <= ex_valid && !ex_is_store && (ex_rd != '0);
  end

  always_ff @(posedge clk)
  begin
    wb_rd   <= ex_rd;
    wb_data <= ex_is_load ? dmem_rdata : ex_result;
  end

  a_dmem_align: assert property (@(posedge clk) disable iff (!arst_n)
    (dmem_wr_en || dmem_rd_en) |-> (dmem_addr[1:0] == 2'b00));

  // load and store flags come from one decoded opcode
  a_dmem_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(dmem_wr_en && dmem_rd_en));

endmodule

`default_nettype wire

// File: src/rv_core.sv
`timescale 1ns/10ps
`default_nettype none
// ---------------------------------------------------------------------
// five-stage RV32I core, memories live outside
// imem_data and dmem_rdata must be returned in the same cycle
// ---------------------------------------------------------------------

module rv_core #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          arst_n,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_data,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t dmem_wdata,
  output logic          dmem_wr_en,
  output logic          dmem_rd_en,
  input  rv_pkg::word_t dmem_rdata,
  output logic          halt
);
  import rv_pkg::*;

  logic         stall;
  logic         redirect;
  word_t        redirect_pc;
  logic         if_valid;
  word_t        if_pc;
  word_t        if_instr;
  reg_addr_t    rs1;
  reg_addr_t    rs2;
  word_t        rs1_data;
  word_t        rs2_data;
  logic         id_valid;
  word_t        id_pc;
  opcode_e      id_opcode;
  alu_op_e      id_alu_op;
  branch_cond_e id_br_cond;
  reg_addr_t    id_rs1;
  reg_addr_t    id_rs2;
  reg_addr_t    id_rd;
  word_t        id_imm;
  word_t        id_rs1_data;
  word_t        id_rs2_data;
  logic         ex_valid;
  reg_addr_t    ex_rd;
  word_t        ex_result;
  word_t        ex_store_data;
  logic         ex_is_load;
  logic         ex_is_store;
  logic         wb_en;
  reg_addr_t    wb_rd;
  word_t        wb_data;

  rv_fetch #(.RESET_PC(RESET_PC)) i_fetch (
    .clk, .arst_n, .stall, .redirect, .redirect_pc,
    .imem_addr, .imem_data, .if_valid, .if_pc, .if_instr, .halt
  );

  rv_regfile i_regfile (
    .clk, .arst_n, .rs1, .rs2, .rs1_data, .rs2_data,
    .wr_en (wb_en), .wr_addr (wb_rd), .wr_data (wb_data)
  );

  rv_decode i_decode (
    .clk, .arst_n, .if_valid, .if_pc, .if_instr, .redirect,
    .ex_valid, .ex_rd, .ex_is_load, .rs1, .rs2, .rs1_data, .rs2_data, .stall,
    .id_valid, .id_pc, .id_opcode, .id_alu_op, .id_br_cond,
    .id_rs1, .id_rs2, .id_rd, .id_imm, .id_rs1_data, .id_rs2_data
  );

  rv_execute i_execute (
    .clk, .arst_n, .id_valid, .id_pc, .id_opcode, .id_alu_op, .id_br_cond,
    .id_rs1, .id_rs2, .id_rd, .id_imm, .id_rs1_data, .id_rs2_data,
    .wb_en, .wb_rd, .wb_data, .redirect, .redirect_pc,
    .ex_valid, .ex_rd, .ex_result, .ex_store_data, .ex_is_load, .ex_is_store
  );

  rv_memwb i_memwb (
    .clk, .arst_n, .ex_valid, .ex_rd, .ex_result, .ex_store_data,
    .ex_is_load, .ex_is_store, .dmem_addr, .dmem_wdata, .dmem_wr_en,
    .dmem_rd_en, .dmem_rdata, .wb_en, .wb_rd, .wb_data
  );

endmodule

`default_nettype wire

// File: verif/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none
// ----------------------------------------------------------------------
// directed testbench for rv_core, both memories are modelled here
// programs and data stay in the first 1 KiB, higher addresses wrap
// data memory is reloaded from dinit while reset is held
// ----------------------------------------------------------------------

module tb_rv_core;
  import rv_pkg::*;

  localparam int    MEM_WORDS    = 256;
  localparam int    HALT_TIMEOUT = 2000;    // cycles from reset release
  localparam int    CHAIN_BASE   = 'h100;
  localparam int    BR_BASE      = 'h340;
  localparam word_t MARK_ADDR    = 32'h3f0;

  // {alt, funct3}: ten register ops, then nine immediate ops
  localparam logic [3:0] OP_TABLE [0:18] = '{
    4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7,
    4'h0, 4'h2, 4'h3, 4'h4, 4'h6, 4'h7, 4'h1, 4'h5, 4'hd
  };
  localparam logic [2:0] BR_F3 [0:5] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

  logic       clk;
  logic       arst_n;
  word_t      imem_addr;
  word_t      imem_data;
  word_t      dmem_addr;
  word_t      dmem_wdata;
  logic       dmem_wr_en;
  logic       dmem_rd_en;
  word_t      dmem_rdata;
  logic       halt;
  word_t      imem  [0:MEM_WORDS-1];
  word_t      dmem  [0:MEM_WORDS-1];
  word_t      dinit [0:MEM_WORDS-1];
  logic [7:0] prog_len;              // next free instruction slot
  int         seed = 32'h5df78b9d;
  int         checks;
  int         errors;

  rv_core #(.RESET_PC(32'h0)) i_dut (
    .clk, .arst_n, .imem_addr, .imem_data, .dmem_addr, .dmem_wdata,
    .dmem_wr_en, .dmem_rd_en, .dmem_rdata, .halt
  );

  always #4 clk = ~clk;

  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem_rd_en ? dmem[dmem_addr[9:2]] : '0;

  always @(posedge clk)
  begin
    if (!arst_n)
      dmem <= dinit;
    else if (dmem_wr_en)
      dmem[dmem_addr[9:2]] <= dmem_wdata;
  end

  function automatic word_t rtype(input logic [6:0] f7, input logic [2:0] f3,
                                  input logic [4:0] rd, input logic [4:0] rs1,
                                  input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t itype(input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic word_t load_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic word_t stype(input logic [4:0] rs2, input logic [4:0] rs1,
                                  input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t btype(input logic [2:0] f3, input logic [4:0] rs1,
                                  input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t utype(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  // ISA reference for the integer ops, b is rs2 or the sign-extended immediate
  function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
    word_t y;
    case (f3)
      3'b000:  y = alt ? a - b : a + b;
      3'b001:  y = a << b[4:0];
      3'b010:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  y = (a < b) ? 32'd1 : 32'd0;
      3'b100:  y = a ^ b;
      3'b101:  y = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  y = a | b;
      default: y = a & b;
    endcase
    return y;
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
    logic t;
    case (f3)
      3'd0:    t = (a == b);
      3'd1:    t = (a != b);
      3'd4:    t = $signed(a) < $signed(b);
      3'd5:    t = $signed(a) >= $signed(b);
      3'd6:    t = a < b;
      default: t = a >= b;
    endcase
    return t;
  endfunction

  // background data, every word differs and none is zero
  function automatic word_t fill_word(input word_t addr);
    return {16'hc0de, 6'b0, addr[9:0]};
  endfunction

  function automatic word_t read_dmem(input word_t addr);
    return dmem[addr[9:2]];
  endfunction

  task automatic compare_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic put_instr(input word_t instr);
    imem[prog_len] = instr;
    prog_len++;
  endtask

  task automatic preload(input word_t addr, input word_t value);
    dinit[addr[9:2]] = value;
  endtask

  // lui + addi, upper part rounded for the signed low half
  task automatic load_imm32(input logic [4:0] rd, input word_t value);
    word_t upper;
    upper = value + 32'h800;
    put_instr(utype(rd, upper[31:12]));
    put_instr(itype(3'b000, rd, rd, value[11:0]));
  endtask

  task automatic new_program();
    @(posedge clk);
    arst_n <= 1'b0;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      imem[i[7:0]]  = '0;    // unused words read as the stop word
      dinit[i[7:0]] = fill_word(word_t'(i * 4));
    end
    prog_len = '0;
  endtask

  // hold reset, release, wait for halt, then watch the halted core
  task automatic run_program(input string name);
    int cyc;
    for (int i = 0; i < 8; i++)
    begin
      @(negedge clk);
      compare_bit("halt in reset", 1'b0, halt);
    end
    @(posedge clk);
    arst_n <= 1'b1;
    cyc = 0;
    while ((halt !== 1'b1) && (cyc < HALT_TIMEOUT))
    begin
      @(negedge clk);
      cyc++;
    end
    if (halt !== 1'b1)
    begin
      errors++;
      $display("timeout: %s did not halt within %0d cycles", name, HALT_TIMEOUT);
    end
    else
    begin
      for (int i = 0; i < 20; i++)
      begin
        @(negedge clk);
        compare_bit("halt after halt", 1'b1, halt);
        compare_bit("dmem_wr_en after halt", 1'b0, dmem_wr_en);
        compare_bit("dmem_rd_en after halt", 1'b0, dmem_rd_en);
      end
    end
  endtask

  // groups of four dependent ops, sources at distance 1, 2 and 3
  task automatic alu_chain_test();
    word_t      v1;
    word_t      v2;
    word_t      a;
    word_t      b;
    word_t      r;
    word_t      first;
    word_t      prev;
    word_t      addr;
    word_t      exp_q [$];
    logic [11:0] imm;
    logic [4:0] rd;
    logic [4:0] src1;
    logic [4:0] src2;
    logic [2:0] f3;
    logic       alt;
    int         op;
    new_program();
    first = '0;
    prev  = '0;
    for (int g = 0; g < 5; g++)
    begin
      v1 = $random(seed);
      v2 = $random(seed);
      load_imm32(5'd1, v1);
      load_imm32(5'd2, v2);
      for (int s = 0; s < 4; s++)
      begin
        op   = (g * 4 + s) % 19;
        rd   = 5'd10 + 5'(s);
        src1 = (s == 0) ? 5'd1 : rd - 5'd1;
        src2 = (s < 2) ? 5'd2 : 5'd10;
        a    = (s == 0) ? v1 : prev;
        b    = (s < 2) ? v2 : first;
        {alt, f3} = OP_TABLE[op[4:0]];
        r = $random(seed);
        if (op >= 10)
        begin
          imm = ((f3 == 3'b001) || (f3 == 3'b101)) ? {1'b0, alt, 5'b0, r[4:0]} : r[11:0];
          b   = {{20{imm[11]}}, imm};
          put_instr(itype(f3, rd, src1, imm));
        end
        else
          put_instr(rtype(alt ? 7'h20 : 7'h00, f3, rd, src1, src2));
        prev = alu_model(f3, alt, a, b);
        if (s == 0)
          first = prev;
        exp_q.push_back(prev);
      end
      for (int s = 0; s < 4; s++)
        put_instr(stype(5'd10 + 5'(s), 5'd0, 12'(CHAIN_BASE + (g * 4 + s) * 4)));
    end
    run_program("alu chain");
    for (int k = 0; k < exp_q.size(); k++)
    begin
      addr = word_t'(CHAIN_BASE + k * 4);
      compare_word($sformatf("dmem[%h]", addr), exp_q[k], read_dmem(addr));
    end
  endtask

  task automatic load_use_test();
    word_t k;
    word_t d0;
    word_t d1;
    word_t u;
    word_t uw;
    new_program();
    k  = $random(seed);
    d0 = $random(seed);
    d1 = $random(seed);
    u  = $random(seed);
    uw = {u[19:0], 12'h000};
    preload(32'h200, d0);
    preload(32'h204, d1);
    load_imm32(5'd3, k);
    put_instr(load_instr(5'd4, 5'd0, 12'h200));
    put_instr(rtype(7'h00, 3'b000, 5'd5, 5'd4, 5'd3));   // uses the load at once
    put_instr(stype(5'd5, 5'd0, 12'h300));
    put_instr(utype(5'd6, u[19:0]));
    put_instr(rtype(7'h00, 3'b000, 5'd7, 5'd6, 5'd3));
    put_instr(stype(5'd6, 5'd0, 12'h304));
    put_instr(stype(5'd7, 5'd0, 12'h308));
    put_instr(load_instr(5'd8, 5'd0, 12'h204));
    put_instr(stype(5'd8, 5'd0, 12'h30c));               // store data from the load
    run_program("load use");
    compare_word("dmem[300]", d0 + k, read_dmem(32'h300));
    compare_word("dmem[304]", uw, read_dmem(32'h304));
    compare_word("dmem[308]", uw + k, read_dmem(32'h308));
    compare_word("dmem[30c]", d1, read_dmem(32'h30c));
  endtask

  // each condition once taken and once not, wrong paths store to the marker
  task automatic branch_test();
    word_t      neg;
    word_t      pos;
    word_t      slot;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [2:0] f3;
    logic       taken;
    int         n;
    new_program();
    neg = $random(seed) | 32'h8000_0000;
    pos = $random(seed) & 32'h7fff_ffff;
    load_imm32(5'd1, neg);
    load_imm32(5'd2, pos);
    load_imm32(5'd31, 32'h0bad_0bad);
    n = 0;
    for (int c = 0; c < 6; c++)
    begin
      for (int p = 0; p < 2; p++)
      begin
        f3 = BR_F3[c[2:0]];
        if (f3 < 3'd2)
        begin
          ra = 5'd1;
          rb = (p == 0) ? 5'd1 : 5'd2;
        end
        else
        begin
          ra = (p == 0) ? 5'd1 : 5'd2;
          rb = (p == 0) ? 5'd2 : 5'd1;
        end
        taken = branch_model(f3, (ra == 5'd1) ? neg : pos, (rb == 5'd1) ? neg : pos);
        slot  = word_t'(BR_BASE + n * 4);
        put_instr(btype(f3, ra, rb, 13'd12));
        if (taken)
        begin
          put_instr(stype(5'd31, 5'd0, MARK_ADDR[11:0]));
          put_instr(stype(5'd31, 5'd0, MARK_ADDR[11:0]));
          put_instr(stype(5'd2, 5'd0, slot[11:0]));
        end
        else
        begin
          put_instr(stype(5'd2, 5'd0, slot[11:0]));
          put_instr(btype(3'd0, 5'd0, 5'd0, 13'd8));      // jump over the marker store
          put_instr(stype(5'd31, 5'd0, MARK_ADDR[11:0]));
        end
        n++;
      end
    end
    run_program("branches");
    for (int i = 0; i < n; i++)
    begin
      slot = word_t'(BR_BASE + i * 4);
      compare_word($sformatf("dmem[%h]", slot), pos, read_dmem(slot));
    end
    compare_word("dmem[marker]", fill_word(MARK_ADDR), read_dmem(MARK_ADDR));
  endtask

  task automatic x0_write_test();
    word_t v;
    new_program();
    v = $random(seed) | 32'h1;
    load_imm32(5'd1, v);
    put_instr(itype(3'b000, 5'd0, 5'd1, 12'h005));
    put_instr(stype(5'd0, 5'd0, 12'h3e0));
    put_instr(rtype(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
    put_instr(stype(5'd0, 5'd0, 12'h3e4));
    put_instr(rtype(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
    put_instr(itype(3'b000, 5'd9, 5'd1, 12'h000));       // spacer, x0 read at distance 2
    put_instr(stype(5'd0, 5'd0, 12'h3e8));
    run_program("x0 write");
    compare_word("dmem[3e0]", 32'h0, read_dmem(32'h3e0));
    compare_word("dmem[3e4]", 32'h0, read_dmem(32'h3e4));
    compare_word("dmem[3e8]", 32'h0, read_dmem(32'h3e8));
  endtask

  // a zero word on the not-taken side of a branch must not stop the core
  task automatic halt_skip_test();
    word_t v;
    new_program();
    v = $random(seed);
    load_imm32(5'd5, v);
    put_instr(btype(3'd0, 5'd0, 5'd0, 13'd8));
    put_instr(32'h0000_0000);
    put_instr(stype(5'd5, 5'd0, 12'h3d0));
    run_program("halt skip");
    compare_word("dmem[3d0]", v, read_dmem(32'h3d0));
  endtask

  initial
  begin
    #500000;
    $display("watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

  initial
  begin
    clk      = 1'b0;
    arst_n   = 1'b0;
    checks   = 0;
    errors   = 0;
    prog_len = '0;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      imem[i[7:0]]  = '0;
      dinit[i[7:0]] = fill_word(word_t'(i * 4));
    end
    alu_chain_test();
    load_use_test();
    branch_test();
    x0_write_test();
    halt_skip_test();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
src/rv_pkg.sv
src/rv_alu.sv
src/rv_regfile.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_memwb.sv
src/rv_core.sv
verif/tb_rv_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rv_core
FILELIST  = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
